/* Makefile */
TOP = system86_video_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f system86_video.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f system86_video.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* common/sys86_consts.svh */
`ifndef SYS86_CONSTS_SVH
`define SYS86_CONSTS_SVH

////////////////////
// pixel clock
////////////////////

// 48 MHz master down to 6 MHz dots
`define SYS86_PIX_DIV 8

////////////////////
// horizontal timing in pixels
////////////////////

`define SYS86_H_TOTAL 384
`define SYS86_H_ACTIVE 288
`define SYS86_HSYNC_START 304
`define SYS86_HSYNC_LEN 32

////////////////////
// vertical timing in lines
////////////////////

`define SYS86_V_TOTAL 264
`define SYS86_V_ACTIVE 224
`define SYS86_VSYNC_START 240
`define SYS86_VSYNC_LEN 3

// bank bit on top of the 8 bit dot index
`define SYS86_PAL_ADDR_W 9

`endif

/* common/sys86_pkg.sv */
`include "sys86_consts.svh"

package sys86_pkg;

	// colour index from the tile and sprite mixer
	typedef logic [7:0] dot_t;

	// one 4 bit colour channel
	typedef logic [3:0] nibble_t;

	// 3r prom word
	// red in the low nibble, green above it
	typedef struct packed {
		nibble_t green;
		nibble_t red;
	} rg_entry_t;

	// 3s prom word
	// only the low nibble is wired to the blue dac
	typedef struct packed {
		logic [3:0] unused;
		nibble_t blue;
	} b_entry_t;

	// {bank, dot}
	typedef logic [`SYS86_PAL_ADDR_W-1:0] pal_addr_t;

	// frame boundary controller
	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_SHOW,
		ST_PENDING
	} ctrl_state_t;

endpackage

/* rtl/system86_video.sv */
module system86_video (
	input logic clk_48m,
	input logic rst_n,
	input sys86_pkg::dot_t dot,
	input logic bank_sel,
	input logic clear_req,
	input logic pal_wr_rg,
	input logic pal_wr_b,
	input sys86_pkg::pal_addr_t pal_addr,
	input logic [7:0] pal_data,
	output logic pix_en,
	output sys86_pkg::nibble_t red,
	output sys86_pkg::nibble_t green,
	output sys86_pkg::nibble_t blue,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n,
	output logic comp_sync_n
);

	// raw timing, aligned to the counters
	logic hsync_raw_n;
	logic vsync_raw_n;
	logic hblank_raw_n;
	logic vblank_raw_n;
	logic comp_sync_raw_n;
	logic frame_start;

	// applied frame settings
	logic bank;
	logic video_on;

	////////////////////
	// timing
	////////////////////

	// counters left open here
	// nothing downstream needs the beam position
	video_timing u_timing (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.h_count(),
		.v_count(),
		.hsync_n(hsync_raw_n),
		.vsync_n(vsync_raw_n),
		.hblank_n(hblank_raw_n),
		.vblank_n(vblank_raw_n),
		.comp_sync_n(comp_sync_raw_n),
		.frame_start(frame_start)
	);

	////////////////////
	// bank and clear control
	////////////////////

	videogen_ctrl u_ctrl (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.bank_sel(bank_sel),
		.clear_req(clear_req),
		.bank(bank),
		.video_on(video_on)
	);

	////////////////////
	// palette path
	////////////////////

	videogen_pipe u_pipe (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.dot(dot),
		.bank(bank),
		.video_on(video_on),
		.hsync_n(hsync_raw_n),
		.vsync_n(vsync_raw_n),
		.hblank_n(hblank_raw_n),
		.vblank_n(vblank_raw_n),
		.comp_sync_n(comp_sync_raw_n),
		.pal_wr_rg(pal_wr_rg),
		.pal_wr_b(pal_wr_b),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync_out_n(hsync_n),
		.vsync_out_n(vsync_n),
		.hblank_out_n(hblank_n),
		.vblank_out_n(vblank_n),
		.comp_sync_out_n(comp_sync_n)
	);

endmodule

/* sim/system86_stim.txt */
# W R|B addr data : palette write, 3r word is green:red, 3s word low nibble is blue
# B v : bank request, C v : clear request, T : timing check, F : next frame
# D dot r g b : dot with its palette colour in the applied bank (hex)
W R 010 21
W B 010 03
W R 022 54
W B 022 06
W R 03c 87
W B 03c 09
W R 0a5 ba
W B 0a5 0c
W R 110 fe
W B 110 0d
W R 122 13
W B 122 0e
W R 13c 9c
W B 13c 01
W R 1a5 42
W B 1a5 07
# screen cleared until the first boundary
D 10 1 2 3
D 22 4 5 6
T
F
D 10 1 2 3
D 3c 7 8 9
D a5 a b c
# bank change waits for the boundary
B 1
D 22 4 5 6
F
D 22 3 1 e
D 10 e f d
# rewrite one entry
W R 122 77
D 22 7 7 e
C 1
D 3c c 9 1
F
D 3c c 9 1
C 0
D a5 2 4 7
F
D a5 2 4 7
D 10 e f d

/* sim/system86_video_asserts.sv */
module system86_video_asserts #(
	parameter bit TIMING_SIDE = 1'b1
) (
	input logic clk_48m,
	input logic rst_n,
	input logic pix_en,
	input logic frame_start,
	input logic bank,
	input logic hsync_n,
	input logic vsync_n
);

	timeunit 1ns;
	timeprecision 100ps;

	if (TIMING_SIDE) begin : g_timing

		////////////////////
		// timing checks
		////////////////////

		// 6 MHz enable is a one clock pulse
		a_pix_single: assert property (@(posedge clk_48m) disable iff (rst_n)
			pix_en |=> !pix_en)
			else $error("pix_en high on two clocks in a row");

		// syncs idle high through reset
		// first reset clock skipped, counters still unknown there
		a_sync_reset: assert property (@(posedge clk_48m)
			(rst_n && $past(rst_n)) |-> (hsync_n && vsync_n))
			else $error("sync active during reset");

	end else begin : g_ctrl

		////////////////////
		// controller checks
		////////////////////

		// bank only moves on the frame boundary
		a_bank_frame: assert property (@(posedge clk_48m) disable iff (rst_n)
			(bank != $past(bank)) |-> $past(frame_start))
			else $error("bank changed away from frame_start");

	end

endmodule

/* sim/system86_video_tb.sv */
`include "sys86_consts.svh"

module system86_video_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import sys86_pkg::*;

	localparam int LIMIT = 1000000;
	localparam int LINE_CLKS = `SYS86_H_TOTAL * `SYS86_PIX_DIV;
	localparam int FRAME_CLKS = LINE_CLKS * `SYS86_V_TOTAL;
	localparam int HBLANK_PIX = `SYS86_H_TOTAL - `SYS86_H_ACTIVE;
	localparam int DEPTH = 2 ** `SYS86_PAL_ADDR_W;

	logic clk_48m;
	logic rst_n;
	dot_t dot;
	logic bank_sel;
	logic clear_req;
	logic pal_wr_rg;
	logic pal_wr_b;
	pal_addr_t pal_addr;
	logic [7:0] pal_data;
	logic pix_en;
	nibble_t red;
	nibble_t green;
	nibble_t blue;
	logic hsync_n;
	logic vsync_n;
	logic hblank_n;
	logic vblank_n;
	logic comp_sync_n;

	// palette model, 3r and 3s words
	logic [7:0] rg_model [0:DEPTH-1];
	logic [7:0] b_model [0:DEPTH-1];
	// what the controller should have applied at the last boundary
	logic applied_bank;
	logic applied_on;

	int checks;
	int mismatches;
	int file_errs;

	system86_video UUT (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.dot(dot),
		.bank_sel(bank_sel),
		.clear_req(clear_req),
		.pal_wr_rg(pal_wr_rg),
		.pal_wr_b(pal_wr_b),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.pix_en(pix_en),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n),
		.comp_sync_n(comp_sync_n)
	);

	bind video_timing system86_video_asserts #(.TIMING_SIDE(1'b1)) u_timing_chk (
		.clk_48m(clk_48m), .rst_n(rst_n), .pix_en(pix_en), .frame_start(frame_start),
		.bank(1'b0), .hsync_n(hsync_n), .vsync_n(vsync_n)
	);

	bind videogen_ctrl system86_video_asserts #(.TIMING_SIDE(1'b0)) u_ctrl_chk (
		.clk_48m(clk_48m), .rst_n(rst_n), .pix_en(1'b0), .frame_start(frame_start),
		.bank(bank), .hsync_n(1'b1), .vsync_n(1'b1)
	);

	// 48 MHz stand in, 4 ns period
	always #2 clk_48m = ~clk_48m;

	////////////////////
	// wait helpers
	////////////////////

	task automatic give_up(input string what);
		$display("timeout while waiting for %0s at %0t", what, $time);
		$display("checks %0d, mismatches %0d, file errors %0d", checks, mismatches, file_errs);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// returns on the falling edge just before the sampling edge
	task automatic wait_pix;
		int n;
		n = 0;
		do begin
			@(negedge clk_48m);
			n++;
		end while (!pix_en && n < LIMIT);
		if (!pix_en) begin
			give_up("pix_en");
		end
	endtask

	function automatic logic pick(input int which);
		case (which)
			0: return hsync_n;
			1: return vsync_n;
			default: return vblank_n;
		endcase
	endfunction

	// counts clocks until the chosen output reaches level
	// colours must stay black wherever the delayed blanks are low
	task automatic wait_level(input int which, input logic level, output int clks);
		clks = 0;
		do begin
			@(negedge clk_48m);
			clks++;
			if ((!hblank_n || !vblank_n) && ({red, green, blue} != 12'h000)) begin
				mismatches++;
				$display("mismatch at %0t: colour %h%h%h during blanking", $time, red, green,
					blue);
			end
		end while (pick(which) != level && clks < LIMIT);
		if (pick(which) != level) begin
			give_up("a sync or blank edge");
		end
	endtask

	////////////////////
	// stimulus actions
	////////////////////

	task automatic write_pal(input logic is_rg, input pal_addr_t a, input logic [7:0] d);
		@(negedge clk_48m);
		pal_addr = a;
		pal_data = d;
		pal_wr_rg = is_rg;
		pal_wr_b = !is_rg;
		@(negedge clk_48m);
		pal_wr_rg = 1'b0;
		pal_wr_b = 1'b0;
		if (is_rg) begin
			rg_model[a] = d;
		end else begin
			b_model[a] = d;
		end
	endtask

	// line and frame periods, hblank and composite sync widths
	task automatic measure_timing;
		int c1;
		int c2;
		int low_pix;
		int comp_pix;
		wait_level(0, 1'b0, c1);
		wait_level(0, 1'b1, c1);
		wait_level(0, 1'b0, c2);
		checks++;
		if (c1 + c2 != LINE_CLKS) begin
			mismatches++;
			$display("mismatch at %0t: hsync period %0d clocks, expected %0d", $time, c1 + c2,
				LINE_CLKS);
		end
		low_pix = 0;
		comp_pix = 0;
		// one full line away from vsync
		repeat (`SYS86_H_TOTAL) begin
			wait_pix();
			if (!hblank_n) begin
				low_pix++;
			end
			if (!comp_sync_n) begin
				comp_pix++;
			end
		end
		checks++;
		if (low_pix != HBLANK_PIX) begin
			mismatches++;
			$display("mismatch at %0t: hblank %0d pixels, expected %0d", $time, low_pix,
				HBLANK_PIX);
		end
		checks++;
		if (comp_pix != `SYS86_HSYNC_LEN) begin
			mismatches++;
			$display("mismatch at %0t: composite sync %0d pixels, expected %0d", $time,
				comp_pix, `SYS86_HSYNC_LEN);
		end
		wait_level(1, 1'b0, c1);
		wait_level(1, 1'b1, c1);
		wait_level(1, 1'b0, c2);
		checks++;
		if (c1 + c2 != FRAME_CLKS) begin
			mismatches++;
			$display("mismatch at %0t: vsync period %0d clocks, expected %0d", $time, c1 + c2,
				FRAME_CLKS);
		end
	endtask

	// through vblank into the next visible frame
	// frame_start has passed once vblank shows at the output
	task automatic next_frame;
		int c;
		wait_level(2, 1'b0, c);
		wait_level(2, 1'b1, c);
		applied_bank = bank_sel;
		applied_on = !clear_req;
	endtask

	task automatic check_dot(input logic [7:0] d, input nibble_t fr, input nibble_t fg,
		input nibble_t fb);
		pal_addr_t a;
		logic [11:0] model_rgb;
		logic [11:0] exp_rgb;
		a = {applied_bank, d};
		model_rgb = {rg_model[a][3:0], rg_model[a][7:4], b_model[a][3:0]};
		if ({fr, fg, fb} !== model_rgb) begin
			file_errs++;
			$display("stimulus file colour for dot %h disagrees with the palette model", d);
		end
		// dot taken on the next sampling edge
		wait_pix();
		dot = d;
		// prom read lands on the following one, filler behind it
		wait_pix();
		dot = 8'($urandom());
		@(negedge clk_48m);
		// dot checks belong inside the visible window
		if (!hblank_n || !vblank_n) begin
			file_errs++;
			$display("dot %h was checked during blanking, the stimulus is out of step", d);
		end
		exp_rgb = applied_on ? model_rgb : 12'h000;
		checks++;
		if ({red, green, blue} !== exp_rgb) begin
			mismatches++;
			$display("mismatch at %0t: dot %h gave rgb %h%h%h, expected %h", $time, d, red,
				green, blue, exp_rgb);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int fd;
		int code;
		logic done;
		logic [63:0] cmd;
		logic [63:0] sel;
		logic [8:0] addr_v;
		logic [7:0] data_v;
		logic [7:0] dot_v;
		logic [3:0] r_v;
		logic [3:0] g_v;
		logic [3:0] b_v;
		logic [3:0] flag_v;
		logic [8*128-1:0] line_buf;

		clk_48m = 1'b0;
		rst_n = 1'b1;
		dot = '0;
		bank_sel = 1'b0;
		clear_req = 1'b0;
		pal_wr_rg = 1'b0;
		pal_wr_b = 1'b0;
		pal_addr = '0;
		pal_data = '0;
		applied_bank = 1'b0;
		applied_on = 1'b0;
		checks = 0;
		mismatches = 0;
		file_errs = 0;
		void'($urandom(32'h15ce_3f8f));

		repeat (8) @(negedge clk_48m);
		// everything idle while held
		checks++;
		if (!(hsync_n && vsync_n && hblank_n && vblank_n && comp_sync_n) || pix_en ||
			({red, green, blue} != 12'h000)) begin
			mismatches++;
			$display("mismatch at %0t: outputs not idle in reset", $time);
		end
		rst_n = 1'b0;

		fd = $fopen("sim/system86_stim.txt", "r");
		if (fd == 0) begin
			file_errs++;
			$display("could not open the stimulus file");
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, "%s", cmd);
				if (code != 1) begin
					done = 1'b1;
				end else if (cmd == "#") begin
					code = $fgets(line_buf, fd);
				end else if (cmd == "W") begin
					code = $fscanf(fd, "%s %h %h", sel, addr_v, data_v);
					write_pal(sel == "R", addr_v, data_v);
				end else if (cmd == "B") begin
					code = $fscanf(fd, "%h", flag_v);
					@(negedge clk_48m);
					bank_sel = flag_v[0];
				end else if (cmd == "C") begin
					code = $fscanf(fd, "%h", flag_v);
					@(negedge clk_48m);
					clear_req = flag_v[0];
				end else if (cmd == "T") begin
					measure_timing();
				end else if (cmd == "F") begin
					next_frame();
				end else if (cmd == "D") begin
					code = $fscanf(fd, "%h %h %h %h", dot_v, r_v, g_v, b_v);
					check_dot(dot_v, r_v, g_v, b_v);
				end else begin
					file_errs++;
					$display("unknown stimulus command %0s", cmd);
				end
			end
			$fclose(fd);
		end

		$display("checks %0d, mismatches %0d, file errors %0d", checks, mismatches, file_errs);
		if (mismatches == 0 && file_errs == 0 && checks > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* system86_video.f */
+incdir+common
common/sys86_pkg.sv
timing/video_timing.sv
videogen/palette_prom.sv
videogen/videogen_ctrl.sv
videogen/videogen_pipe.sv
rtl/system86_video.sv
sim/system86_video_asserts.sv
sim/system86_video_tb.sv

/* timing/video_timing.sv */
`include "sys86_consts.svh"

module video_timing (
	input logic clk_48m,
	input logic rst_n,
	output logic pix_en,
	output logic [$clog2(`SYS86_H_TOTAL)-1:0] h_count,
	output logic [$clog2(`SYS86_V_TOTAL)-1:0] v_count,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n,
	output logic comp_sync_n,
	output logic frame_start
);

	localparam int HW = $clog2(`SYS86_H_TOTAL);
	localparam int VW = $clog2(`SYS86_V_TOTAL);

	localparam logic [2:0] DIV_LAST = 3'(`SYS86_PIX_DIV - 1);

	localparam logic [HW-1:0] H_LAST = HW'(`SYS86_H_TOTAL - 1);
	localparam logic [HW-1:0] H_ACT = HW'(`SYS86_H_ACTIVE);
	localparam logic [HW-1:0] HS_BEG = HW'(`SYS86_HSYNC_START);
	localparam logic [HW-1:0] HS_END = HW'(`SYS86_HSYNC_START + `SYS86_HSYNC_LEN);

	localparam logic [VW-1:0] V_LAST = VW'(`SYS86_V_TOTAL - 1);
	localparam logic [VW-1:0] V_ACT = VW'(`SYS86_V_ACTIVE);
	localparam logic [VW-1:0] V_ACT_LAST = VW'(`SYS86_V_ACTIVE - 1);
	localparam logic [VW-1:0] VS_BEG = VW'(`SYS86_VSYNC_START);
	localparam logic [VW-1:0] VS_END = VW'(`SYS86_VSYNC_START + `SYS86_VSYNC_LEN);

	logic [2:0] div;
	logic h_last;

	////////////////////
	// 6 MHz pixel enable
	////////////////////

	// pix_en registered off the last divider step
	// first pulse lands 8 clocks out of reset
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			div <= '0;
			pix_en <= 1'b0;
		end else begin
			div <= (div == DIV_LAST) ? '0 : div + 1'b1;
			pix_en <= (div == DIV_LAST);
		end
	end

	////////////////////
	// pixel and line counters
	////////////////////

	assign h_last = (h_count == H_LAST);

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			h_count <= '0;
			v_count <= '0;
		end else if (pix_en) begin
			if (h_last) begin
				h_count <= '0;
				// line wraps after the last vblank line
				v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	////////////////////
	// sync and blank decode
	////////////////////

	// straight off the counters
	// counters at 0 leave everything inactive
	assign hblank_n = (h_count < H_ACT);
	assign hsync_n = !((h_count >= HS_BEG) && (h_count < HS_END));
	assign vblank_n = (v_count < V_ACT);
	assign vsync_n = !((v_count >= VS_BEG) && (v_count < VS_END));

	// either sync low pulls composite low
	assign comp_sync_n = hsync_n & vsync_n;

	// the step from the last visible line into the first blank one
	assign frame_start = pix_en && h_last && (v_count == V_ACT_LAST);

endmodule

/* videogen/palette_prom.sv */
`include "sys86_consts.svh"

module palette_prom #(
	parameter type entry_t = logic [7:0]
) (
	input logic clk_48m,
	input logic rst_n,
	input logic wr,
	input sys86_pkg::pal_addr_t wr_addr,
	input entry_t wr_data,
	input sys86_pkg::pal_addr_t rd_addr,
	input logic rd_en,
	output entry_t rd_data
);

	localparam int DEPTH = 1 << `SYS86_PAL_ADDR_W;

	// prom contents
	// filled through the write port before use
	entry_t mem [0:DEPTH-1];

	////////////////////
	// load port
	////////////////////

	// lands on the strobe clock
	always_ff @(posedge clk_48m) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////
	// registered read
	////////////////////

	// one word per pixel enable
	// same clock write and read returns the old word
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* videogen/videogen_ctrl.sv */
module videogen_ctrl (
	input logic clk_48m,
	input logic rst_n,
	input logic frame_start,
	input logic bank_sel,
	input logic clear_req,
	output logic bank,
	output logic video_on
);

	import sys86_pkg::*;

	ctrl_state_t state;

	// requested setting differs from the applied one
	logic req_diff;
	// take the request on this clock
	logic apply;

	////////////////////
	// request compare
	////////////////////

	// video_on is the inverse of clear
	// so equal values mean a pending change
	assign req_diff = (bank_sel != bank) || (clear_req == video_on);

	// only ever on the frame boundary
	// and only for a request already noted as pending
	assign apply = frame_start && (state == ST_PENDING);

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			state <= ST_CLEAR;
			bank <= 1'b0;
			video_on <= 1'b0;
		end else if (apply) begin
			bank <= bank_sel;
			video_on <= !clear_req;
			state <= clear_req ? ST_CLEAR : ST_SHOW;
		end else begin
			case (state)
				ST_CLEAR, ST_SHOW: begin
					// hold until the next boundary
					if (req_diff) begin
						state <= ST_PENDING;
					end
				end
				ST_PENDING: begin
					// request withdrawn before the boundary
					if (!req_diff) begin
						state <= video_on ? ST_SHOW : ST_CLEAR;
					end
				end
				default: begin
					state <= ST_CLEAR;
				end
			endcase
		end
	end

endmodule

/* videogen/videogen_pipe.sv */
module videogen_pipe (
	input logic clk_48m,
	input logic rst_n,
	input logic pix_en,
	input sys86_pkg::dot_t dot,
	input logic bank,
	input logic video_on,
	input logic hsync_n,
	input logic vsync_n,
	input logic hblank_n,
	input logic vblank_n,
	input logic comp_sync_n,
	input logic pal_wr_rg,
	input logic pal_wr_b,
	input sys86_pkg::pal_addr_t pal_addr,
	input logic [7:0] pal_data,
	output sys86_pkg::nibble_t red,
	output sys86_pkg::nibble_t green,
	output sys86_pkg::nibble_t blue,
	output logic hsync_out_n,
	output logic vsync_out_n,
	output logic hblank_out_n,
	output logic vblank_out_n,
	output logic comp_sync_out_n
);

	import sys86_pkg::*;

	pal_addr_t rd_addr;
	rg_entry_t rg_word;
	b_entry_t b_word;

	// {comp, vblank, hblank, vsync, hsync}
	logic [4:0] sync_raw;
	logic [4:0] sync_d1;
	logic [4:0] sync_d2;

	logic show;

	////////////////////
	// stage 1 dot latch
	////////////////////

	// bank rides along as the top address bit
	always_ff @(posedge clk_48m) begin
		if (pix_en) begin
			rd_addr <= {bank, dot};
		end
	end

	////////////////////
	// stage 2 palette proms
	////////////////////

	// 3r red and green
	palette_prom #(
		.entry_t(rg_entry_t)
	) u_prom_3r (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.wr(pal_wr_rg),
		.wr_addr(pal_addr),
		.wr_data(rg_entry_t'(pal_data)),
		.rd_addr(rd_addr),
		.rd_en(pix_en),
		.rd_data(rg_word)
	);

	// 3s blue
	palette_prom #(
		.entry_t(b_entry_t)
	) u_prom_3s (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.wr(pal_wr_b),
		.wr_addr(pal_addr),
		.wr_data(b_entry_t'(pal_data)),
		.rd_addr(rd_addr),
		.rd_en(pix_en),
		.rd_data(b_word)
	);

	////////////////////
	// sync delay
	////////////////////

	// two pixel enables to match the dot path
	assign sync_raw = {comp_sync_n, vblank_n, hblank_n, vsync_n, hsync_n};

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			sync_d1 <= '1;
			sync_d2 <= '1;
		end else if (pix_en) begin
			sync_d1 <= sync_raw;
			sync_d2 <= sync_d1;
		end
	end

	assign hsync_out_n = sync_d2[0];
	assign vsync_out_n = sync_d2[1];
	assign hblank_out_n = sync_d2[2];
	assign vblank_out_n = sync_d2[3];
	assign comp_sync_out_n = sync_d2[4];

	////////////////////
	// blank forcing
	////////////////////

	// black outside the visible window or when cleared
	assign show = hblank_out_n & vblank_out_n & video_on;

	assign red = show ? rg_word.red : '0;
	assign green = show ? rg_word.green : '0;
	assign blue = show ? b_word.blue : '0;

endmodule
